//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_cpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard source/*.sv) $(wildcard bench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/program_input.txt
# kind value [value], all hex: n executed instruction count, i instruction word in order,
# d initial data word (byte address, value), s expected store (byte address, value)
n 0000002e  # 46 instructions reach execute, break included
i 34011234  # 00 ori   r1, r0, 0x1234
i 2402fff0  # 04 addiu r2, r0, -16
i 00221821  # 08 addu  r3, r1, r2
i ac030100  # 0c sw    r3, 0x100(r0)
i 00222023  # 10 subu  r4, r1, r2
i ac040104  # 14 sw    r4, 0x104(r0)
i 00222824  # 18 and   r5, r1, r2
i ac050108  # 1c sw    r5, 0x108(r0)
i 00223025  # 20 or    r6, r1, r2
i ac06010c  # 24 sw    r6, 0x10c(r0)
i 00223826  # 28 xor   r7, r1, r2
i ac070110  # 2c sw    r7, 0x110(r0)
i 0041402a  # 30 slt   r8, r2, r1
i ac080114  # 34 sw    r8, 0x114(r0)
i 00014900  # 38 sll   r9, r1, 4
i ac090118  # 3c sw    r9, 0x118(r0)
i 00025202  # 40 srl   r10, r2, 8
i ac0a011c  # 44 sw    r10, 0x11c(r0)
i 3c0bbeef  # 48 lui   r11, 0xbeef
i 304c0ff0  # 4c andi  r12, r2, 0x0ff0
i ac0b0120  # 50 sw    r11, 0x120(r0)
i 284dffff  # 54 slti  r13, r2, -1
i ac0c0124  # 58 sw    r12, 0x124(r0)
i ac0d0128  # 5c sw    r13, 0x128(r0)
i 242e0001  # 60 addiu r14, r1, 1
i 01ce7821  # 64 addu  r15, r14, r14
i 01ee8023  # 68 subu  r16, r15, r14
i 020f8826  # 6c xor   r17, r16, r15
i ac11012c  # 70 sw    r17, 0x12c(r0)
i 8c120200  # 74 lw    r18, 0x200(r0)
i 26530077  # 78 addiu r19, r18, 0x77
i ac130130  # 7c sw    r19, 0x130(r0)
i 8c140204  # 80 lw    r20, 0x204(r0)
i 0281a821  # 84 addu  r21, r20, r1
i ac150134  # 88 sw    r21, 0x134(r0)
i 8c160100  # 8c lw    r22, 0x100(r0)
i ac160138  # 90 sw    r22, 0x138(r0)
i 102e0002  # 94 beq   r1, r14, 0xa0 not taken
i ac01013c  # 98 sw    r1, 0x13c(r0)
i 142e0002  # 9c bne   r1, r14, 0xa8 taken
i ac020140  # a0 sw    r2, 0x140(r0) skipped
i ac030144  # a4 sw    r3, 0x144(r0) skipped
i 120e0002  # a8 beq   r16, r14, 0xb4 taken
i ac040148  # ac sw    r4, 0x148(r0) skipped
i ac05014c  # b0 sw    r5, 0x14c(r0) skipped
i 08000030  # b4 j     0xc0
i ac060150  # b8 sw    r6, 0x150(r0) skipped
i ac070154  # bc sw    r7, 0x154(r0) skipped
i 150d0002  # c0 bne   r8, r13, 0xcc not taken
i ac090158  # c4 sw    r9, 0x158(r0)
i ac0a015c  # c8 sw    r10, 0x15c(r0)
i 0000000d  # cc break (funct 0d)
i ac0b0160  # d0 sw    r11, 0x160(r0) never
i ac0c0164  # d4 sw    r12, 0x164(r0) never
d 00000200 0badf00d
d 00000204 7ffffff0
s 00000100 00001224  # addu
s 00000104 00001244  # subu
s 00000108 00001230  # and
s 0000010c fffffff4  # or
s 00000110 ffffedc4  # xor
s 00000114 00000001  # slt
s 00000118 00012340  # sll
s 0000011c 00ffffff  # srl
s 00000120 beef0000  # lui
s 00000124 00000ff0  # andi
s 00000128 00000001  # slti
s 0000012c 0000365f  # dependent chain
s 00000130 0badf084  # load plus offset 0x77
s 00000134 80001224  # load plus r1
s 00000138 00001224  # load of an earlier store
s 0000013c 00001234  # after not-taken beq
s 00000158 00012340  # after not-taken bne
s 0000015c 00ffffff  # last store before break

//--- bench/tb_mips_cpu.sv
module tb_mips_cpu;

    localparam int ADDR_WIDTH = 16;

    logic                  clk;
    logic                  reset;
    logic [ADDR_WIDTH-1:0] imem_addr;
    mips_pkg::word_t       imem_data;
    logic                  dmem_enable;
    logic                  dmem_write_enable;
    mips_pkg::word_t       dmem_addr;
    mips_pkg::word_t       dmem_wdata;
    mips_pkg::word_t       dmem_rdata;
    logic                  dmem_ready;
    logic                  halted;

    mips_pkg::word_t rom [256];
    mips_pkg::word_t data_mem [256];
    mips_pkg::word_t store_addr_queue [$];
    mips_pkg::word_t store_data_queue [$];

    int exec_count;
    int cycle_count;
    int cycle_limit;
    int check_count;
    int error_count;
    int store_count;

    logic [31:0] lfsr;
    logic [2:0]  wait_left;    // wait states still owed to the open request
    logic        request_open;

    mips_cpu #(.ADDR_WIDTH(ADDR_WIDTH)) i_dut (
        .clk(clk),
        .reset(reset),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .dmem_enable(dmem_enable),
        .dmem_write_enable(dmem_write_enable),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata),
        .dmem_ready(dmem_ready),
        .halted(halted)
    );

    always #4 clk = ~clk;

    assign imem_data = rom[imem_addr[9:2]]; // combinational program rom

    ////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h80200003;
        else
            return state >> 1;
    endfunction

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("ERROR %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("ERROR %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic record_store(input mips_pkg::word_t addr, input mips_pkg::word_t data);
        if (store_count >= store_addr_queue.size())
        begin
            error_count++;
            $display("unexpected store to %h beyond the expected sequence", addr);
        end
        else
        begin
            check_word("dmem_addr", addr, store_addr_queue[store_count]);
            check_word("dmem_wdata", data, store_data_queue[store_count]);
        end
        store_count++;
    endtask

    task automatic load_input();
        int          fd;
        int          fields;
        int          rom_count;
        string       line;
        logic [7:0]  kind;
        logic [31:0] value_a;
        logic [31:0] value_b;

        rom_count = 0;
        fd = $fopen("bench/program_input.txt", "r");
        if (fd == 0)
        begin
            error_count++;
            $display("cannot open bench/program_input.txt");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                kind = 8'h00; // blank lines leave it untouched
                fields = $sscanf(line, "%c %h %h", kind, value_a, value_b);
                if ((kind == "d" || kind == "s") && fields < 3)
                begin
                    error_count++;
                    $display("malformed line in input file: %s", line);
                end
                else
                begin
                    case (kind)
                        "n": exec_count = int'(value_a);
                        "i":
                        begin
                            rom[rom_count[7:0]] = value_a;
                            rom_count++;
                        end
                        "d": data_mem[value_a[9:2]] = value_b;
                        "s":
                        begin
                            store_addr_queue.push_back(value_a);
                            store_data_queue.push_back(value_b);
                        end
                        default: ; // comment line
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // data memory with random wait states

    always @(posedge clk)
    begin
        if (!reset && dmem_enable && dmem_ready)
        begin
            if (dmem_addr[31:10] != '0 || dmem_addr[1:0] != 2'b00)
            begin
                error_count++;
                $display("data access to %h is outside the modeled word memory", dmem_addr);
            end
            if (dmem_write_enable)
            begin
                record_store(dmem_addr, dmem_wdata);
                data_mem[dmem_addr[9:2]] = dmem_wdata;
            end
            request_open = 1'b0;
        end
        #1;
        if (reset || !dmem_enable)
        begin
            dmem_ready = 1'b0;
            request_open = 1'b0;
        end
        else
        begin
            if (!request_open)
            begin
                request_open = 1'b1;
                for (int i = 0; i < 3; i++)
                begin
                    lfsr = lfsr_next(lfsr);
                    wait_left = {wait_left[1:0], lfsr[0]};
                end
            end
            if (wait_left == 3'd0)
            begin
                dmem_ready = 1'b1;
                dmem_rdata = data_mem[dmem_addr[9:2]];
            end
            else
            begin
                dmem_ready = 1'b0;
                wait_left = wait_left - 3'd1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles without halting and draining", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // main sequence

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        request_open = 1'b0;
        wait_left = 3'd0;
        lfsr = 32'h4a7b8a48;
        exec_count = 0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        store_count = 0;
        for (int i = 0; i < 256; i++)
        begin
            rom[i[7:0]] = '0; // nop
            data_mem[i[7:0]] = 32'h9e3779b9 * i;
        end
        load_input();
        cycle_limit = exec_count * 12 + 200;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        @(negedge clk); // state left by reset
        check_word("imem_addr", mips_pkg::word_t'(imem_addr), 32'h0);
        check_bit("dmem_enable", dmem_enable, 1'b0);
        check_bit("halted", halted, 1'b0);

        do
            @(negedge clk);
        while (halted !== 1'b1);
        // store just before break may still wait for ready
        do
            @(negedge clk);
        while (dmem_enable === 1'b1);
        repeat (16) @(negedge clk); // window for a stray late store

        check_bit("halted", halted, 1'b1);
        check_word("store count", mips_pkg::word_t'(store_count),
                   mips_pkg::word_t'(store_addr_queue.size()));

        $display("checks %0d, errors %0d, stores %0d of %0d", check_count, error_count,
                 store_count, store_addr_queue.size());
        if (error_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- source/alu.sv
module alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    output mips_pkg::word_t   result,
    output logic              equal
);

    always_comb
    begin
        case (op)
            mips_pkg::ALU_ADD: result = a + b;
            mips_pkg::ALU_SUB: result = a - b;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_XOR: result = a ^ b;
            mips_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            mips_pkg::ALU_SLL: result = b << shamt; // shifts act on rt
            mips_pkg::ALU_SRL: result = b >> shamt;
            mips_pkg::ALU_LUI: result = {b[15:0], 16'b0};
            default:           result = a;
        endcase
    end

    assign equal = (a == b); // beq / bne

endmodule

//--- source/decoder.sv
module decoder (
    input  mips_pkg::word_t     inst,
    input  mips_pkg::word_t     pc,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic                rs_enable,
    output logic                rt_enable,
    output mips_pkg::reg_addr_t rd,
    output mips_pkg::word_t     imm,
    output mips_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output logic                mem_enable,
    output logic                mem_write,
    output logic                wb_reg,
    output logic                wb_mem,
    output logic                branch,
    output logic                branch_ne,
    output logic                jump,
    output mips_pkg::word_t     target,
    output logic                brk
);

    logic [5:0] opcode;
    logic [5:0] funct;
    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t sign_imm;

    assign opcode = inst[31:26];
    assign funct = inst[5:0];
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign pc_plus4 = pc + 32'd4;
    assign sign_imm = {{16{inst[15]}}, inst[15:0]};

    always_comb
    begin
        rs_enable = 1'b0;
        rt_enable = 1'b0;
        rd = inst[20:16]; // immediate forms write rt
        imm = sign_imm;
        alu_op = mips_pkg::ALU_ADD;
        use_imm = 1'b0;
        mem_enable = 1'b0;
        mem_write = 1'b0;
        wb_reg = 1'b0;
        wb_mem = 1'b0;
        branch = 1'b0;
        branch_ne = 1'b0;
        jump = 1'b0;
        brk = 1'b0;
        target = pc_plus4 + {sign_imm[29:0], 2'b00};

        case (opcode)
            mips_pkg::OP_SPECIAL:
            begin
                rd = inst[15:11];
                rs_enable = 1'b1;
                rt_enable = 1'b1;
                wb_reg = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_BREAK:
                    begin
                        brk = 1'b1;
                        wb_reg = 1'b0;
                        rs_enable = 1'b0; // code field, not registers
                        rt_enable = 1'b0;
                    end
                    default: wb_reg = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
            mips_pkg::OP_LUI:
            begin
                rs_enable = (opcode != mips_pkg::OP_LUI);
                use_imm = 1'b1;
                wb_reg = 1'b1;
                if (opcode == mips_pkg::OP_SLTI)
                    alu_op = mips_pkg::ALU_SLT;
                else if (opcode == mips_pkg::OP_ANDI)
                    alu_op = mips_pkg::ALU_AND;
                else if (opcode == mips_pkg::OP_ORI)
                    alu_op = mips_pkg::ALU_OR;
                else if (opcode == mips_pkg::OP_LUI)
                    alu_op = mips_pkg::ALU_LUI;
                // logical forms zero extend
                if (opcode == mips_pkg::OP_ANDI || opcode == mips_pkg::OP_ORI ||
                    opcode == mips_pkg::OP_LUI)
                    imm = {16'b0, inst[15:0]};
            end
            mips_pkg::OP_LW:
            begin
                rs_enable = 1'b1;
                use_imm = 1'b1;
                mem_enable = 1'b1;
                wb_reg = 1'b1;
                wb_mem = 1'b1;
            end
            mips_pkg::OP_SW:
            begin
                rs_enable = 1'b1;
                rt_enable = 1'b1; // store data
                use_imm = 1'b1;
                mem_enable = 1'b1;
                mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE:
            begin
                rs_enable = 1'b1;
                rt_enable = 1'b1;
                alu_op = mips_pkg::ALU_SUB;
                branch = 1'b1;
                branch_ne = (opcode == mips_pkg::OP_BNE);
            end
            mips_pkg::OP_J:
            begin
                jump = 1'b1;
                target = {pc_plus4[31:28], inst[25:0], 2'b00};
            end
            default: ; // unknown opcodes act as nop
        endcase
    end

endmodule

//--- source/fetch_unit.sv
module fetch_unit #(
    parameter ADDR_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  branch,
    input  logic [ADDR_WIDTH-1:0] branch_target,
    input  logic                  halt,
    output logic [ADDR_WIDTH-1:0] pc
);

    logic frozen; // set by break, cleared only by reset

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
            frozen <= 1'b0;
        end
        else if (halt || frozen)
            frozen <= 1'b1;
        else if (!stall)
        begin
            if (branch)
                pc <= branch_target;
            else
                pc <= pc + ADDR_WIDTH'(4);
        end
    end

endmodule

//--- source/forwarding_unit.sv
module forwarding_unit (
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                rs_enable,
    input  logic                rt_enable,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    input  logic                exec_wb_reg,
    input  mips_pkg::reg_addr_t exec_write_addr,
    input  mips_pkg::word_t     exec_result,
    input  logic                mem_wb_reg,
    input  mips_pkg::reg_addr_t mem_write_addr,
    input  mips_pkg::word_t     mem_result,
    input  logic                wb_wb_reg,
    input  mips_pkg::reg_addr_t wb_write_addr,
    input  mips_pkg::word_t     wb_result,
    output mips_pkg::word_t     rs_forward,
    output mips_pkg::word_t     rt_forward
);

    // youngest producer wins, register zero never forwards
    assign rs_forward = (!rs_enable || rs == 5'd0)             ? rs_data :
                        (exec_wb_reg && exec_write_addr == rs) ? exec_result :
                        (mem_wb_reg && mem_write_addr == rs)   ? mem_result :
                        (wb_wb_reg && wb_write_addr == rs)     ? wb_result :
                        rs_data;

    assign rt_forward = (!rt_enable || rt == 5'd0)             ? rt_data :
                        (exec_wb_reg && exec_write_addr == rt) ? exec_result :
                        (mem_wb_reg && mem_write_addr == rt)   ? mem_result :
                        (wb_wb_reg && wb_write_addr == rt)     ? wb_result :
                        rt_data;

endmodule

//--- source/mips_cpu.sv
module mips_cpu #(
    parameter ADDR_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic [ADDR_WIDTH-1:0] imem_addr,
    input  mips_pkg::word_t       imem_data,
    output logic                  dmem_enable,
    output logic                  dmem_write_enable,
    output mips_pkg::word_t       dmem_addr,
    output mips_pkg::word_t       dmem_wdata,
    input  mips_pkg::word_t       dmem_rdata,
    input  logic                  dmem_ready,
    output logic                  halted
);

    logic fetch_stall;
    logic decode_stall;
    logic decode_flush;
    logic exec_flush;
    logic mem_stall;

    logic [ADDR_WIDTH-1:0] fetch_pc;
    logic [ADDR_WIDTH-1:0] dec_pc;
    mips_pkg::word_t       dec_inst;

    mips_pkg::reg_addr_t dec_rs;
    mips_pkg::reg_addr_t dec_rt;
    mips_pkg::reg_addr_t dec_rd;
    logic                dec_rs_enable;
    logic                dec_rt_enable;
    mips_pkg::word_t     dec_imm;
    mips_pkg::alu_op_t   dec_alu_op;
    logic                dec_use_imm;
    logic                dec_mem_enable;
    logic                dec_mem_write;
    logic                dec_wb_reg;
    logic                dec_wb_mem;
    logic                dec_branch;
    logic                dec_branch_ne;
    logic                dec_jump;
    mips_pkg::word_t     dec_target;
    logic                dec_brk;
    mips_pkg::word_t     dec_rs_data;
    mips_pkg::word_t     dec_rt_data;
    mips_pkg::word_t     fwd_rs;
    mips_pkg::word_t     fwd_rt;

    mips_pkg::alu_op_t     ex_alu_op;
    mips_pkg::word_t       ex_a;
    mips_pkg::word_t       ex_b;
    mips_pkg::word_t       ex_store_data;
    logic [4:0]            ex_shamt;
    mips_pkg::reg_addr_t   ex_write_addr;
    logic                  ex_wb_reg;
    logic                  ex_wb_mem;
    logic                  ex_mem_enable;
    logic                  ex_mem_write;
    logic                  ex_branch;
    logic                  ex_branch_ne;
    logic                  ex_jump;
    logic                  ex_brk;
    logic [ADDR_WIDTH-1:0] ex_target;
    mips_pkg::word_t       ex_result;
    logic                  ex_equal;
    logic                  ex_take_branch;

    mips_pkg::word_t     mem_alu;
    mips_pkg::word_t     mem_store_data;
    mips_pkg::reg_addr_t mem_write_addr;
    logic                mem_wb_reg;
    logic                mem_wb_mem;
    logic                mem_enable;
    logic                mem_write;
    mips_pkg::word_t     mem_result;

    logic                wb_wb_reg;
    mips_pkg::reg_addr_t wb_write_addr;
    mips_pkg::word_t     wb_data;

    ////////////////////////////////////////
    // fetch

    fetch_unit #(.ADDR_WIDTH(ADDR_WIDTH)) fetch (
        .clk(clk),
        .reset(reset),
        .stall(fetch_stall),
        .branch(ex_take_branch),
        .branch_target(ex_target),
        .halt(ex_brk),
        .pc(fetch_pc)
    );

    assign imem_addr = fetch_pc;

    always_ff @(posedge clk)
    begin
        if (reset)
            dec_inst <= '0;
        else if (!decode_stall)
            dec_inst <= (decode_flush || halted) ? '0 : imem_data; // all zero is a nop
    end

    always_ff @(posedge clk)
    begin
        if (!decode_stall)
            dec_pc <= fetch_pc;
    end

    ////////////////////////////////////////
    // decode

    decoder decode (
        .inst(dec_inst),
        .pc(mips_pkg::word_t'(dec_pc)),
        .rs(dec_rs),
        .rt(dec_rt),
        .rs_enable(dec_rs_enable),
        .rt_enable(dec_rt_enable),
        .rd(dec_rd),
        .imm(dec_imm),
        .alu_op(dec_alu_op),
        .use_imm(dec_use_imm),
        .mem_enable(dec_mem_enable),
        .mem_write(dec_mem_write),
        .wb_reg(dec_wb_reg),
        .wb_mem(dec_wb_mem),
        .branch(dec_branch),
        .branch_ne(dec_branch_ne),
        .jump(dec_jump),
        .target(dec_target),
        .brk(dec_brk)
    );

    register_file regfile (
        .clk(clk),
        .reset(reset),
        .rs(dec_rs),
        .rt(dec_rt),
        .rs_data(dec_rs_data),
        .rt_data(dec_rt_data),
        .write_enable(wb_wb_reg),
        .write_addr(wb_write_addr),
        .write_data(wb_data)
    );

    forwarding_unit forward (
        .rs(dec_rs),
        .rt(dec_rt),
        .rs_enable(dec_rs_enable),
        .rt_enable(dec_rt_enable),
        .rs_data(dec_rs_data),
        .rt_data(dec_rt_data),
        .exec_wb_reg(ex_wb_reg),
        .exec_write_addr(ex_write_addr),
        .exec_result(ex_result),
        .mem_wb_reg(mem_wb_reg),
        .mem_write_addr(mem_write_addr),
        .mem_result(mem_result),
        .wb_wb_reg(wb_wb_reg),
        .wb_write_addr(wb_write_addr),
        .wb_result(wb_data),
        .rs_forward(fwd_rs),
        .rt_forward(fwd_rt)
    );

    pipeline_control control (
        .dec_rs(dec_rs),
        .dec_rt(dec_rt),
        .dec_rs_enable(dec_rs_enable),
        .dec_rt_enable(dec_rt_enable),
        .exec_load(ex_wb_mem),
        .exec_write_addr(ex_write_addr),
        .exec_take_branch(ex_take_branch),
        .exec_brk(ex_brk),
        .mem_enable(mem_enable),
        .dmem_ready(dmem_ready),
        .fetch_stall(fetch_stall),
        .decode_stall(decode_stall),
        .decode_flush(decode_flush),
        .exec_flush(exec_flush),
        .mem_stall(mem_stall)
    );

    always_ff @(posedge clk)
    begin
        if (reset || (!mem_stall && exec_flush))
        begin
            ex_wb_reg <= 1'b0;
            ex_wb_mem <= 1'b0;
            ex_mem_enable <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch <= 1'b0;
            ex_jump <= 1'b0;
            ex_brk <= 1'b0;
        end
        else if (!mem_stall)
        begin
            ex_wb_reg <= dec_wb_reg;
            ex_wb_mem <= dec_wb_mem;
            ex_mem_enable <= dec_mem_enable;
            ex_mem_write <= dec_mem_write;
            ex_branch <= dec_branch;
            ex_jump <= dec_jump;
            ex_brk <= dec_brk;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!mem_stall)
        begin
            ex_alu_op <= dec_alu_op;
            ex_a <= fwd_rs;
            ex_b <= dec_use_imm ? dec_imm : fwd_rt;
            ex_store_data <= fwd_rt;
            ex_shamt <= dec_inst[10:6];
            ex_write_addr <= dec_rd;
            ex_branch_ne <= dec_branch_ne;
            ex_target <= dec_target[ADDR_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////
    // execute

    alu exec_alu (
        .op(ex_alu_op),
        .a(ex_a),
        .b(ex_b),
        .shamt(ex_shamt),
        .result(ex_result),
        .equal(ex_equal)
    );

    assign ex_take_branch = ex_jump || (ex_branch && (ex_equal != ex_branch_ne));

    always_ff @(posedge clk)
    begin
        if (reset)
            halted <= 1'b0;
        else if (ex_brk)
            halted <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_wb_reg <= 1'b0;
            mem_wb_mem <= 1'b0;
            mem_enable <= 1'b0;
            mem_write <= 1'b0;
        end
        else if (!mem_stall)
        begin
            mem_wb_reg <= ex_wb_reg;
            mem_wb_mem <= ex_wb_mem;
            mem_enable <= ex_mem_enable;
            mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!mem_stall)
        begin
            mem_alu <= ex_result;
            mem_store_data <= ex_store_data;
            mem_write_addr <= ex_write_addr;
        end
    end

    ////////////////////////////////////////
    // memory and writeback

    // held stable by mem_stall until dmem_ready
    assign dmem_enable = mem_enable;
    assign dmem_write_enable = mem_write;
    assign dmem_addr = mem_alu;
    assign dmem_wdata = mem_store_data;

    assign mem_result = mem_wb_mem ? dmem_rdata : mem_alu;

    always_ff @(posedge clk)
    begin
        if (reset)
            wb_wb_reg <= 1'b0;
        else
            wb_wb_reg <= mem_wb_reg && !mem_stall; // bubble while waiting
    end

    always_ff @(posedge clk)
    begin
        wb_write_addr <= mem_write_addr;
        wb_data <= mem_result;
    end

endmodule

//--- source/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    ////////////////////////////////////////
    // alu operations
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;
    localparam alu_op_t ALU_SLL = 4'd6;
    localparam alu_op_t ALU_SRL = 4'd7;
    localparam alu_op_t ALU_LUI = 4'd8;

    ////////////////////////////////////////
    // opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field of OP_SPECIAL
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_BREAK = 6'h0d;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

endpackage

//--- source/pipeline_control.sv
module pipeline_control (
    input  mips_pkg::reg_addr_t dec_rs,
    input  mips_pkg::reg_addr_t dec_rt,
    input  logic                dec_rs_enable,
    input  logic                dec_rt_enable,
    input  logic                exec_load,
    input  mips_pkg::reg_addr_t exec_write_addr,
    input  logic                exec_take_branch,
    input  logic                exec_brk,
    input  logic                mem_enable,
    input  logic                dmem_ready,
    output logic                fetch_stall,
    output logic                decode_stall,
    output logic                decode_flush,
    output logic                exec_flush,
    output logic                mem_stall
);

    logic mem_wait;
    logic load_use;
    logic redirect;

    assign mem_wait = mem_enable && !dmem_ready;

    // load in execute feeding decode, data not ready yet
    assign load_use = exec_load && exec_write_addr != 5'd0 &&
                      ((dec_rs_enable && dec_rs == exec_write_addr) ||
                       (dec_rt_enable && dec_rt == exec_write_addr));

    assign redirect = exec_take_branch || exec_brk;

    assign mem_stall = mem_wait;
    assign fetch_stall = mem_wait || load_use;
    assign decode_stall = mem_wait || load_use;
    assign decode_flush = !mem_wait && redirect;
    assign exec_flush = !mem_wait && (redirect || load_use); // bubble into execute

endmodule

//--- source/register_file.sv
module register_file (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  logic                write_enable,
    input  mips_pkg::reg_addr_t write_addr,
    input  mips_pkg::word_t     write_data
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (write_enable && write_addr != 5'd0)
            regs[write_addr] <= write_data;
    end

    // writeback in the same cycle bypasses the array
    assign rs_data = (write_enable && write_addr != 5'd0 && write_addr == rs) ?
                     write_data : regs[rs];
    assign rt_data = (write_enable && write_addr != 5'd0 && write_addr == rt) ?
                     write_data : regs[rt];

endmodule

//--- tb.f
source/mips_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/register_file.sv
source/forwarding_unit.sv
source/alu.sv
source/pipeline_control.sv
source/mips_cpu.sv
bench/tb_mips_cpu.sv
